/* build.f */
logic/xbus_io_pkg.sv
logic/ready_channel.sv
logic/vector_select.sv
logic/tick_timers.sv
logic/input_latches.sv
logic/xbus_decode.sv
logic/xbus_io.sv
tb/xbus_io_tb.sv

/* logic/input_latches.sv */
`timescale 1ns/1ps
`default_nettype none

module input_latches (
   input  wire                     clk,
   input  wire                     reset,
   input  wire [15:0]              kb_data,
   input  wire                     kb_ready,
   input  wire xbus_io_pkg::mouse_pos_t ms_x,
   input  wire xbus_io_pkg::mouse_pos_t ms_y,
   input  wire [2:0]               ms_button,
   input  wire                     ms_ready,
   output xbus_io_pkg::input_regs_t inputs
);
   import xbus_io_pkg::*;

   // key scan gets the fixed tag on top
   always_ff @(posedge clk)
   begin
      if (reset)
         inputs.key_scan <= '0;
      else if (kb_ready)
         inputs.key_scan <= {KBD_TAG, kb_data};
   end

   // mouse sample held between strobes
   always_ff @(posedge clk)
   begin
      if (reset)
         inputs.mouse <= '0;
      else if (ms_ready)
      begin
         inputs.mouse.head   <= ms_button[2];
         inputs.mouse.middle <= ms_button[1];
         inputs.mouse.tail   <= ms_button[0];
         inputs.mouse.x      <= ms_x;
         inputs.mouse.y      <= ms_y;
      end
   end

endmodule

`default_nettype wire

/* logic/ready_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module ready_channel (
   input  wire  clk,
   input  wire  reset,
   input  wire  set,
   input  wire  clear,
   input  wire  enable,
   output logic ready,
   output logic request
);

   // sticky flag, a read clear beats a new set
   always_ff @(posedge clk)
   begin
      if (reset)
         ready <= 1'b0;
      else if (clear)
         ready <= 1'b0;
      else if (set)
         ready <= 1'b1;
   end

   assign request = ready & enable;

endmodule

`default_nettype wire

/* logic/tick_timers.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_timers #(
   parameter int unsigned us_div   = xbus_io_pkg::DEF_US_DIV,
   parameter int unsigned hz60_div = xbus_io_pkg::DEF_HZ60_DIV
) (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     hz60_start,
   output xbus_io_pkg::timer_regs_t timers,
   output logic                    hz60_tick
);
   import xbus_io_pkg::*;

   xbus_word_t us_pre;
   xbus_word_t hz_pre;
   logic       us_wrap;
   logic       hz60_en;

   assign us_wrap = (us_pre == xbus_word_t'(us_div));

   // free running microsecond count
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         us_pre          <= '0;
         timers.us_clock <= '0;
      end
      else if (us_wrap)
      begin
         us_pre          <= '0;
         timers.us_clock <= timers.us_clock + 1'b1;
      end
      else
         us_pre <= us_pre + 1'b1;
   end

   // 60 Hz side stays idle until the first start
   assign hz60_tick = hz60_en & (hz_pre == xbus_word_t'(hz60_div));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hz60_en           <= 1'b0;
         hz_pre            <= '0;
         timers.hz60_clock <= '0;
      end
      else
      begin
         if (hz60_start)
            hz60_en <= 1'b1;
         if (hz60_tick)
         begin
            hz_pre            <= '0;
            timers.hz60_clock <= timers.hz60_clock + 1'b1;
         end
         else if (hz60_en)
            hz_pre <= hz_pre + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/vector_select.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_select (
   input  wire xbus_io_pkg::chan_mask_t pending,
   output logic                     interrupt,
   output xbus_io_pkg::irq_vector_t vector
);
   import xbus_io_pkg::*;

   logic input_req;

   // mouse and keyboard share one vector
   assign input_req = pending[CH_MOUSE] | pending[CH_KBD];
   assign interrupt = |pending;

   // fixed priority, input devices ahead of the clock
   always_comb
   begin
      if (input_req)
         vector = VEC_INPUT;
      else if (pending[CH_CLK])
         vector = VEC_CLOCK;
      else
         vector = '0;
   end

endmodule

`default_nettype wire

/* logic/xbus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module xbus_decode (
   input  wire                       clk,
   input  wire                       reset,
   input  wire xbus_io_pkg::xbus_addr_t  addr,
   input  wire xbus_io_pkg::xbus_word_t  datain,
   input  wire                       req,
   input  wire                       write,
   input  wire xbus_io_pkg::input_regs_t inputs,
   input  wire xbus_io_pkg::timer_regs_t timers,
   input  wire xbus_io_pkg::chan_mask_t  rdy,
   output logic                      decode,
   output logic                      ack,
   output xbus_io_pkg::xbus_word_t   dataout,
   output xbus_io_pkg::csr_bits_t    csr,
   output xbus_io_pkg::chan_mask_t   clear,
   output logic                      hz60_start
);
   import xbus_io_pkg::*;

   logic [1:0] ack_pipe;
   logic       rd_access;
   logic       wr_access;
   xbus_word_t read_word;

   // block match on the upper address bits only
   assign decode    = req & (addr[21:6] == IOB_BASE[21:6]);
   assign rd_access = decode & ~write;
   assign wr_access = decode & write;
   assign ack       = ack_pipe[1];

   // ack trails each decoded cycle by two clocks
   always_ff @(posedge clk)
   begin
      if (reset)
         ack_pipe <= '0;
      else
         ack_pipe <= {ack_pipe[0], decode};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         csr <= '0;
      else if (wr_access && addr == REG_CSR)
         csr <= datain[3:0];
   end

   // read mux plus the clear side effects of reads
   always_comb
   begin
      read_word  = '0;
      clear      = '0;
      hz60_start = 1'b0;
      case (addr)
         REG_KBD_LO:
         begin
            read_word     = {16'b0, inputs.key_scan[15:0]};
            clear[CH_KBD] = rd_access;
         end
         REG_KBD_HI:
         begin
            read_word     = {16'b0, inputs.key_scan[31:16]};
            clear[CH_KBD] = rd_access;
         end
         REG_MS_Y:
         begin
            read_word       = {17'b0, inputs.mouse.head, inputs.mouse.middle,
                               inputs.mouse.tail, inputs.mouse.y};
            clear[CH_MOUSE] = rd_access;
         end
         // raw quadrature bits not wired, they read as zero
         REG_MS_X:
            read_word = {20'b0, inputs.mouse.x};
         REG_CSR:
            read_word = {25'b0, rdy, csr};
         REG_US_LO:
            read_word = {16'b0, timers.us_clock[15:0]};
         REG_US_HI:
            read_word = {16'b0, timers.us_clock[31:16]};
         REG_HZ60:
         begin
            read_word     = timers.hz60_clock;
            clear[CH_CLK] = rd_access;
            hz60_start    = rd_access;
         end
         // beep has no function
         default:
            read_word = '0;
      endcase
   end

   // read data valid for one cycle after the access only
   always_ff @(posedge clk)
   begin
      if (reset)
         dataout <= '0;
      else if (rd_access)
         dataout <= read_word;
      else
         dataout <= '0;
   end

endmodule

`default_nettype wire

/* logic/xbus_io.sv */
`timescale 1ns/1ps
`default_nettype none

module xbus_io #(
   parameter int unsigned us_div   = xbus_io_pkg::DEF_US_DIV,
   parameter int unsigned hz60_div = xbus_io_pkg::DEF_HZ60_DIV
) (
   input  wire                       clk,
   input  wire                       reset,
   input  wire xbus_io_pkg::xbus_addr_t  addr,
   input  wire xbus_io_pkg::xbus_word_t  datain,
   output xbus_io_pkg::xbus_word_t   dataout,
   input  wire                       req,
   input  wire                       write,
   output logic                      ack,
   output logic                      decode,
   output logic                      interrupt,
   output xbus_io_pkg::irq_vector_t  vector,
   input  wire [15:0]                kb_data,
   input  wire                       kb_ready,
   input  wire xbus_io_pkg::mouse_pos_t  ms_x,
   input  wire xbus_io_pkg::mouse_pos_t  ms_y,
   input  wire [2:0]                 ms_button,
   input  wire                       ms_ready
);
   import xbus_io_pkg::*;

   input_regs_t inputs;
   timer_regs_t timers;
   csr_bits_t   csr;
   chan_mask_t  clear;
   chan_mask_t  set_mask;
   chan_mask_t  en_mask;
   chan_mask_t  rdy;
   chan_mask_t  pending;
   logic        hz60_start;
   logic        hz60_tick;

   // per-source set strobes and CSR enables
   assign set_mask[CH_MOUSE] = ms_ready;
   assign set_mask[CH_KBD]   = kb_ready;
   assign set_mask[CH_CLK]   = hz60_tick;
   assign en_mask[CH_MOUSE]  = csr[1];
   assign en_mask[CH_KBD]    = csr[2];
   assign en_mask[CH_CLK]    = csr[3];

   xbus_decode xbus_decode_inst (
      .clk        (clk),
      .reset      (reset),
      .addr       (addr),
      .datain     (datain),
      .req        (req),
      .write      (write),
      .inputs     (inputs),
      .timers     (timers),
      .rdy        (rdy),
      .decode     (decode),
      .ack        (ack),
      .dataout    (dataout),
      .csr        (csr),
      .clear      (clear),
      .hz60_start (hz60_start)
   );

   input_latches input_latches_inst (
      .clk       (clk),
      .reset     (reset),
      .kb_data   (kb_data),
      .kb_ready  (kb_ready),
      .ms_x      (ms_x),
      .ms_y      (ms_y),
      .ms_button (ms_button),
      .ms_ready  (ms_ready),
      .inputs    (inputs)
   );

   tick_timers #(
      .us_div   (us_div),
      .hz60_div (hz60_div)
   ) tick_timers_inst (
      .clk        (clk),
      .reset      (reset),
      .hz60_start (hz60_start),
      .timers     (timers),
      .hz60_tick  (hz60_tick)
   );

   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_chan
      ready_channel ready_channel_inst (
         .clk     (clk),
         .reset   (reset),
         .set     (set_mask[i]),
         .clear   (clear[i]),
         .enable  (en_mask[i]),
         .ready   (rdy[i]),
         .request (pending[i])
      );
   end

   vector_select vector_select_inst (
      .pending   (pending),
      .interrupt (interrupt),
      .vector    (vector)
   );

endmodule

`default_nettype wire

/* logic/xbus_io_pkg.sv */
`default_nettype none

package xbus_io_pkg;

   // vector types for the bus and the device fields
   typedef logic [21:0] xbus_addr_t;
   typedef logic [31:0] xbus_word_t;
   typedef logic [11:0] mouse_pos_t;
   typedef logic [3:0]  csr_bits_t;
   typedef logic [7:0]  irq_vector_t;

   localparam int NUM_CHAN = 3;
   localparam int CH_MOUSE = 0;
   localparam int CH_KBD   = 1;
   localparam int CH_CLK   = 2;

   typedef logic [NUM_CHAN-1:0] chan_mask_t;

   // 64-word block, only bits 21..6 take part in the compare
   localparam xbus_addr_t IOB_BASE   = 22'o17772000;
   localparam xbus_addr_t REG_KBD_LO = 22'o17772040;
   localparam xbus_addr_t REG_KBD_HI = 22'o17772041;
   localparam xbus_addr_t REG_MS_Y   = 22'o17772042;
   localparam xbus_addr_t REG_MS_X   = 22'o17772043;
   localparam xbus_addr_t REG_BEEP   = 22'o17772044;
   localparam xbus_addr_t REG_CSR    = 22'o17772045;
   localparam xbus_addr_t REG_US_LO  = 22'o17772050;
   localparam xbus_addr_t REG_US_HI  = 22'o17772051;
   localparam xbus_addr_t REG_HZ60   = 22'o17772052;

   // upper half of a key scan: 8 zeros, 5 ones, then 001
   localparam logic [15:0] KBD_TAG = 16'h00F9;

   localparam irq_vector_t VEC_INPUT = 8'o260;
   localparam irq_vector_t VEC_CLOCK = 8'o274;

   localparam int unsigned SYS_CLK_HZ   = 50_000_000;
   localparam int unsigned DEF_US_DIV   = SYS_CLK_HZ / 1_000_000;
   localparam int unsigned DEF_HZ60_DIV = SYS_CLK_HZ / 60;

   typedef struct packed {
      logic       head;
      logic       middle;
      logic       tail;
      mouse_pos_t x;
      mouse_pos_t y;
   } mouse_sample_t;

   typedef struct packed {
      xbus_word_t    key_scan;
      mouse_sample_t mouse;
   } input_regs_t;

   typedef struct packed {
      xbus_word_t us_clock;
      xbus_word_t hz60_clock;
   } timer_regs_t;

endpackage

`default_nettype wire

/* tb/xbus_io_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module xbus_io_tb;
   import xbus_io_pkg::*;

   // longest waits are the two 60 Hz ticks and the 400 and 200 cycle gaps
   localparam int unsigned TIMEOUT_CYCLES = 3000;
   localparam int unsigned US_DIV = 4;
   localparam int unsigned HZ_DIV = 39;

   logic        clk;
   logic        reset;
   xbus_addr_t  addr;
   xbus_word_t  datain;
   xbus_word_t  dataout;
   logic        req;
   logic        write;
   logic        ack;
   logic        decode;
   logic        interrupt;
   irq_vector_t vector;
   logic [15:0] kb_data;
   logic        kb_ready;
   mouse_pos_t  ms_x;
   mouse_pos_t  ms_y;
   logic [2:0]  ms_button;
   logic        ms_ready;

   int unsigned cycle_count;
   logic [31:0] lfsr_state;
   xbus_word_t  rd;
   xbus_word_t  v1;
   int unsigned c1;
   int unsigned c2;
   logic [15:0] code;
   mouse_pos_t  mx;
   mouse_pos_t  my;
   logic [2:0]  mb;
   logic [3:0]  csr_val;

   xbus_io #(.us_div(US_DIV), .hz60_div(HZ_DIV)) xbus_io_inst (
      .clk(clk), .reset(reset), .addr(addr), .datain(datain), .dataout(dataout),
      .req(req), .write(write), .ack(ack), .decode(decode), .interrupt(interrupt),
      .vector(vector), .kb_data(kb_data), .kb_ready(kb_ready), .ms_x(ms_x),
      .ms_y(ms_y), .ms_button(ms_button), .ms_ready(ms_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_run();
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic report_error(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      stop_run();
   endtask

   // galois lfsr stepped once per bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r = {r[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
      end
      return r;
   endfunction

   function automatic bit near(input int got, input int exp);
      return (got <= exp + 1) && (got + 1 >= exp);
   endfunction

   task automatic expect_eq(input xbus_word_t got, input xbus_word_t exp, input string what);
      assert (got === exp)
         else report_error($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   task automatic wait_ack();
      int n;
      n = 0;
      while (ack !== 1'b1 && n < 4)
      begin
         @(negedge clk);
         n++;
      end
      if (ack !== 1'b1)
      begin
         $display("no ack came back from the board");
         stop_run();
      end
   endtask

   task automatic write_reg(input xbus_addr_t a, input xbus_word_t d);
      @(posedge clk);
      req    <= 1'b1;
      write  <= 1'b1;
      addr   <= a;
      datain <= d;
      @(posedge clk);
      req   <= 1'b0;
      write <= 1'b0;
      @(negedge clk);
      wait_ack();
   endtask

   // dataout is valid in the cycle right after the access
   task automatic read_reg(input xbus_addr_t a, output xbus_word_t d, output int unsigned when);
      @(posedge clk);
      when = cycle_count;
      req   <= 1'b1;
      write <= 1'b0;
      addr  <= a;
      @(posedge clk);
      req <= 1'b0;
      @(negedge clk);
      d = dataout;
      wait_ack();
   endtask

   task automatic send_key(input logic [15:0] k);
      @(posedge clk);
      kb_data  <= k;
      kb_ready <= 1'b1;
      @(posedge clk);
      kb_ready <= 1'b0;
      @(negedge clk);
   endtask

   task automatic wait_clock_irq();
      int n;
      n = 0;
      while (interrupt !== 1'b1 && n < 2 * (HZ_DIV + 1))
      begin
         @(negedge clk);
         n++;
      end
      if (interrupt !== 1'b1)
      begin
         $display("the 60 Hz interrupt never arrived");
         stop_run();
      end
   endtask

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
         stop_run();
      end
   end

   // the block spans 64 words upward from its base
   assert property (@(posedge clk)
                    decode == (req && addr >= IOB_BASE && addr <= IOB_BASE + 22'o77))
      else report_error("decode does not match req and block address");
   assert property (@(posedge clk) disable iff (reset) ack == $past(decode, 2))
      else report_error("ack not two cycles after a decoded cycle");
   assert property (@(posedge clk) disable iff (reset)
                    $past(decode && !write) || dataout == '0)
      else report_error("dataout nonzero outside a read cycle");

   initial
   begin
      lfsr_state = 32'd65783;
      reset <= 1'b1;
      req <= 1'b0;
      write <= 1'b0;
      addr <= '0;
      datain <= '0;
      kb_data <= '0;
      kb_ready <= 1'b0;
      ms_x <= '0;
      ms_y <= '0;
      ms_button <= '0;
      ms_ready <= 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      // back-to-back random traffic that never touches the 60 Hz register
      for (int i = 0; i < 40; i++)
      begin
         xbus_addr_t a;
         if (rand_bits(1))
            a = {IOB_BASE[21:6], 6'(rand_bits(6))};
         else
            a = 22'(rand_bits(22));
         if (a == REG_HZ60)
            a = REG_BEEP;
         @(posedge clk);
         req    <= 1'(rand_bits(1));
         write  <= 1'(rand_bits(1));
         addr   <= a;
         datain <= rand_bits(32);
      end
      @(posedge clk);
      req   <= 1'b0;
      write <= 1'b0;
      repeat (4) @(posedge clk);
      read_reg(REG_BEEP, rd, c1);
      expect_eq(rd, '0, "beep read");

      // keyboard with its interrupt enabled
      write_reg(REG_CSR, 32'h4);
      code = 16'(rand_bits(16));
      send_key(code);
      assert (interrupt === 1'b1 && vector === 8'o260)
         else report_error("keyboard interrupt or vector wrong");
      read_reg(REG_CSR, rd, c1);
      expect_eq(rd, 32'h24, "csr with key ready");
      assert (interrupt === 1'b1) else report_error("keyboard interrupt lost on a csr read");
      read_reg(REG_KBD_LO, rd, c1);
      expect_eq(rd, {16'h0, code}, "key code");
      assert (interrupt === 1'b0) else report_error("keyboard interrupt not cleared");
      read_reg(REG_CSR, rd, c1);
      expect_eq(rd, 32'h4, "csr after key read");
      read_reg(REG_KBD_HI, rd, c1);
      expect_eq(rd, 32'h0000_00F9, "key tag");

      // csr readback while every ready bit is clear
      csr_val = 4'(rand_bits(4));
      write_reg(REG_CSR, {28'h0, csr_val});
      read_reg(REG_CSR, rd, c1);
      expect_eq(rd, {28'h0, csr_val}, "csr readback");

      // mouse with its interrupt disabled
      write_reg(REG_CSR, 32'h0);
      mx = 12'(rand_bits(12));
      my = 12'(rand_bits(12));
      mb = 3'(rand_bits(3));
      @(posedge clk);
      ms_x      <= mx;
      ms_y      <= my;
      ms_button <= mb;
      ms_ready  <= 1'b1;
      @(posedge clk);
      ms_ready <= 1'b0;
      @(negedge clk);
      assert (interrupt === 1'b0) else report_error("mouse raised a masked interrupt");
      read_reg(REG_CSR, rd, c1);
      expect_eq(rd, 32'h10, "csr with mouse ready");
      read_reg(REG_MS_Y, rd, c1);
      expect_eq(rd, {17'h0, mb, my}, "mouse buttons and y");
      read_reg(REG_CSR, rd, c1);
      expect_eq(rd, 32'h0, "csr after mouse read");
      read_reg(REG_MS_X, rd, c1);
      expect_eq(rd, {20'h0, mx}, "mouse x");

      // 60 Hz side idle until its register is read
      repeat (60) @(posedge clk);
      read_reg(REG_CSR, rd, c1);
      expect_eq(rd, 32'h0, "clock ready before start");
      write_reg(REG_CSR, 32'h8);
      read_reg(REG_HZ60, rd, c1);
      expect_eq(rd, 32'h0, "60 Hz count before start");
      wait_clock_irq();
      assert (vector === 8'o274) else report_error("clock vector wrong");
      read_reg(REG_CSR, rd, c1);
      expect_eq(rd, 32'h48, "csr with clock ready");

      // keyboard outranks the clock
      write_reg(REG_CSR, 32'hC);
      send_key(16'(rand_bits(16)));
      assert (vector === 8'o260) else report_error("keyboard did not take priority");
      read_reg(REG_KBD_LO, rd, c1);
      assert (interrupt === 1'b1 && vector === 8'o274)
         else report_error("clock vector missing after key read");

      read_reg(REG_HZ60, v1, c1);
      repeat (400) @(posedge clk);
      read_reg(REG_HZ60, rd, c2);
      assert (near(int'(rd - v1), int'((c2 - c1) / (HZ_DIV + 1))))
         else report_error($sformatf("60 Hz count grew by %0d in %0d cycles", rd - v1, c2 - c1));

      // microsecond counter
      read_reg(REG_US_LO, v1, c1);
      repeat (200) @(posedge clk);
      read_reg(REG_US_LO, rd, c2);
      assert (near(int'(16'(rd[15:0] - v1[15:0])), int'((c2 - c1) / (US_DIV + 1))))
         else report_error($sformatf("us count grew by %0d in %0d cycles", rd - v1, c2 - c1));
      read_reg(REG_US_HI, rd, c1);
      expect_eq(rd, (c1 / (US_DIV + 1)) >> 16, "us upper half");

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire
